// ==== files.f ====
+incdir+hw
hw/sap_pkg.sv
hw/sap_request_builder.sv
hw/sap_controller.sv
hw/sap_result_store.sv
hw/sap_master.sv
test/tb_sap_master.sv

// ==== Bender.yml ====
package:
  name: sap_master

sources:
  - include_dirs:
      - hw
    files:
      - hw/sap_pkg.sv
      - hw/sap_request_builder.sv
      - hw/sap_controller.sv
      - hw/sap_result_store.sv
      - hw/sap_master.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_sap_master.sv

// ==== test/tb_sap_master.sv ====
`timescale 1ns/1ps
`include "sap_settings.svh"

module tb_sap_master
	import sap_pkg::*;
();

	logic                         clk;
	logic                         rstn;
	logic [`SAP_HOST_INSTR_W-1:0] host_instruction;
	logic [`SAP_HOST_DATA_W-1:0]  host_data;
	logic                         sap_start;
	logic                         write_complete;
	logic                         data_input_ready;
	sap_slave_rsp_t               slave_rsp;
	sap_slave_req_t               slave_req;
	logic                         init_transaction;
	logic                         sap_operation_done;
	logic [`SAP_OUTPUT_W-1:0]     sap_output;

	// expected side
	logic [`SAP_HOST_INSTR_W-1:0] exp_instr;
	logic [`SAP_HOST_DATA_W-1:0]  exp_data;
	logic [`SAP_OUTPUT_W-1:0]     exp_output;
	sap_slave_req_t               exp_req;
	logic                         started;
	logic                         reject_mode;
	logic                         holdoff_mode;
	logic                         rd_phase;
	logic                         done_q;
	logic                         start_q;
	logic [1:0]                   start_cnt;
	logic                         busy;
	int                           wait_cnt;
	int                           error_count;
	int                           tests_run;
	int                           tests_failed;

	always #20 clk = ~clk;

	sap_master UUT (
		.clk                (clk),
		.rstn               (rstn),
		.host_instruction   (host_instruction),
		.host_data          (host_data),
		.sap_start          (sap_start),
		.write_complete     (write_complete),
		.data_input_ready   (data_input_ready),
		.slave_rsp          (slave_rsp),
		.slave_req          (slave_req),
		.init_transaction   (init_transaction),
		.sap_operation_done (sap_operation_done),
		.sap_output         (sap_output)
	);

	// ####################
	// reference model
	// ####################

	function automatic logic [1023:0] random_wide();
		logic [1023:0] v;
		for (int i = 0; i < 32; i++) begin
			v[i*32 +: 32] = $urandom;
		end
		return v;
	endfunction

	// operand slices and op code for a given host command
	function automatic sap_slave_req_t expected_req(logic [5:0] instr, logic [511:0] data,
		logic rd);
		sap_slave_req_t r;
		r = '0;
		if (instr[5:4] == 2'b01) begin
			case (instr[3:0])
				4'b0001, 4'b0010: begin
					r.text = data[127:0];
					r.key  = data[255:128];
					r.op   = (instr[3:0] == 4'b0001) ? (rd ? OP_ENCRYPT_RD : OP_ENCRYPT_WR)
						: (rd ? OP_DECRYPT_RD : OP_DECRYPT_WR);
				end
				4'b0011: begin
					r.hash_block = data;
					r.op         = rd ? OP_HASH_RD : OP_HASH_WR;
				end
				4'b0100: r.op = rd ? OP_TRNG_RD : OP_TRNG_WR;
				4'b0111: begin
					r.odo_mode = data[4:0];
					r.op       = rd ? OP_ODO_RD : OP_ODO_WR;
				end
				4'b1000: begin
					r.mult_a = data[127:0];
					r.mult_b = data[255:128];
					r.op     = rd ? OP_MULT_RD : OP_MULT_WR;
				end
				default: r = '0;
			endcase
		end
		return r;
	endfunction

	// zero-extended result port of the slave that ran
	function automatic logic [511:0] expected_output(logic [3:0] opc, sap_slave_rsp_t rsp);
		logic [511:0] v;
		v = '0;
		case (opc)
			4'b0001: v[127:0] = rsp.encrypt;
			4'b0010: v[127:0] = rsp.decrypt;
			4'b0011: v[255:0] = rsp.hash;
			4'b0100: v[127:0] = rsp.trng;
			4'b0111: v[7:0]   = rsp.odometer;
			4'b1000: v[127:0] = rsp.mult;
			default: v        = '0;
		endcase
		return v;
	endfunction

	assign exp_req = expected_req(exp_instr, exp_data, rd_phase);

	// phase and edge history seen at the clock edge
	always @(posedge clk) begin
		if (!rstn) begin
			rd_phase  <= 1'b0;
			done_q    <= 1'b0;
			start_q   <= 1'b0;
			start_cnt <= '0;
		end else begin
			if (write_complete) begin
				rd_phase <= 1'b1;
			end else if (data_input_ready) begin
				rd_phase <= 1'b0;
			end
			done_q  <= sap_operation_done;
			start_q <= sap_start;
			if (!sap_start) begin
				start_cnt <= '0;
			end else if (start_cnt != 2'd3) begin
				start_cnt <= start_cnt + 2'd1;
			end
		end
	end

	// ####################
	// slave model
	// ####################

	always @(negedge clk) begin : slave_model
		logic [1023:0] r;
		write_complete   = 1'b0;
		data_input_ready = 1'b0;
		if (!rstn) begin
			busy = 1'b0;
		end else begin
			if (!busy && init_transaction) begin
				busy     = 1'b1;
				wait_cnt = $urandom_range(7, 0);
			end
			if (busy) begin
				if (wait_cnt == 0) begin
					busy = 1'b0;
					if (rd_phase) begin
						r                = random_wide();
						slave_rsp        = r[$bits(sap_slave_rsp_t)-1:0];
						exp_output       = expected_output(exp_instr[3:0], slave_rsp);
						data_input_ready = 1'b1;
					end else begin
						write_complete = 1'b1;
					end
				end else begin
					wait_cnt = wait_cnt - 1;
				end
			end
		end
	end

	// ####################
	// checks
	// ####################

	a_reset_outputs: assert property (@(posedge clk) disable iff (!rstn)
		!started |-> ({init_transaction, sap_operation_done, slave_req.op, sap_output} == '0))
		else report_mismatch("reset outputs", '0,
			$sampled({init_transaction, sap_operation_done, slave_req.op, sap_output}));

	a_request: assert property (@(posedge clk) disable iff (!rstn)
		init_transaction |-> (slave_req == exp_req))
		else report_mismatch("slave_req", $sampled(exp_req), $sampled(slave_req));

	a_result: assert property (@(posedge clk) disable iff (!rstn)
		(sap_operation_done && !done_q) |-> (sap_output == exp_output))
		else report_mismatch("sap_output", $sampled(exp_output), $sampled(sap_output));

	a_holdoff: assert property (@(posedge clk) disable iff (!rstn)
		holdoff_mode |-> (!init_transaction && !sap_operation_done))
		else report_failure("zero-operand encrypt started a transaction or finished");

	a_reject_timing: assert property (@(posedge clk) disable iff (!rstn)
		(reject_mode && sap_start && start_cnt <= 2'd2)
		|-> (sap_operation_done == (start_cnt == 2'd2)))
		else report_mismatch("sap_operation_done", $sampled(start_cnt == 2'd2),
			$sampled(sap_operation_done));

	a_reject_idle: assert property (@(posedge clk) disable iff (!rstn)
		reject_mode |-> !init_transaction)
		else report_failure("rejected instruction raised init_transaction");

	a_done_hold: assert property (@(posedge clk) disable iff (!rstn)
		(done_q && start_q) |-> sap_operation_done)
		else report_mismatch("sap_operation_done", 1'b1, $sampled(sap_operation_done));

	a_done_fall: assert property (@(posedge clk) disable iff (!rstn)
		(done_q && !start_q) |-> !sap_operation_done)
		else report_mismatch("sap_operation_done", 1'b0, $sampled(sap_operation_done));

	task automatic report_mismatch(string name, logic [1169:0] expected, logic [1169:0] actual);
		error_count++;
		$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
	endtask

	task automatic report_failure(string what);
		error_count++;
		$display("%0t: %s", $time, what);
	endtask

	// ####################
	// stimulus
	// ####################

	task automatic abort_run(string what);
		$display("%0t: timeout waiting for %s", $time, what);
		$display("Regression failed");
		$finish;
	endtask

	task automatic apply_reset();
		rstn             = 1'b0;
		sap_start        = 1'b0;
		host_instruction = '0;
		host_data        = '0;
		exp_instr        = '0;
		exp_data         = '0;
		exp_output       = '0;
		started          = 1'b0;
		reject_mode      = 1'b0;
		holdoff_mode     = 1'b0;
		repeat (16) @(negedge clk);
		rstn = 1'b1;
	endtask

	task automatic wait_done(logic level, string what);
		int n;
		n = 0;
		while (sap_operation_done !== level && n < 200) begin
			n++;
			@(negedge clk);
		end
		if (sap_operation_done !== level) begin
			abort_run(what);
		end
	endtask

	task automatic start_op(logic [5:0] instr, logic [511:0] data);
		logic [1023:0] r;
		host_instruction = instr;
		host_data        = data;
		exp_instr        = instr;
		exp_data         = data;
		sap_start        = 1'b1;
		started          = 1'b1;
		@(negedge clk);
		// new data must not reach the slaves once the command is latched
		r         = random_wide();
		host_data = r[511:0];
	endtask

	task automatic run_op(logic [5:0] instr, logic [511:0] data, int hold);
		start_op(instr, data);
		wait_done(1'b1, "sap_operation_done to rise");
		repeat (hold) @(negedge clk);
		sap_start = 1'b0;
		wait_done(1'b0, "sap_operation_done to fall");
	endtask

	task automatic finish_test(string name, int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: FAILED", name);
		end
	endtask

	initial begin
		int            errs;
		logic [1023:0] r;
		logic [5:0]    ops [6];
		void'($urandom(32'hea8a1c65));
		clk              = 1'b0;
		write_complete   = 1'b0;
		data_input_ready = 1'b0;
		slave_rsp        = '0;
		busy             = 1'b0;
		wait_cnt         = 0;
		error_count      = 0;
		tests_run        = 0;
		tests_failed     = 0;
		apply_reset();

		errs = error_count;
		repeat (4) @(negedge clk);
		finish_test("reset values", errs);

		// encrypt, decrypt, hash, trng, odometer, multiply
		ops = '{6'h11, 6'h12, 6'h13, 6'h14, 6'h17, 6'h18};
		foreach (ops[i]) begin
			errs = error_count;
			r    = random_wide();
			run_op(ops[i], r[511:0], $urandom_range(3, 1));
			finish_test($sformatf("instruction %02h", ops[i]), errs);
		end

		errs         = error_count;
		holdoff_mode = 1'b1;
		start_op(6'h11, '0);
		repeat (40) @(negedge clk);
		apply_reset();
		finish_test("zero-operand hold-off", errs);

		errs = error_count;
		run_op(6'h14, '0, 1);
		finish_test("trng with zero data", errs);

		// secure class first and then a PUF opcode
		errs        = error_count;
		reject_mode = 1'b1;
		r           = random_wide();
		run_op(6'h21, r[511:0], 2);
		run_op(6'h15, r[511:0], 1);
		reject_mode = 1'b0;
		finish_test("reject", errs);

		errs = error_count;
		r    = random_wide();
		run_op(6'h18, r[511:0], 8);
		finish_test("done hold", errs);

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== hw/sap_master.sv ====
`timescale 1ns/1ps
`include "sap_settings.svh"

module sap_master
	import sap_pkg::*;
(
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [`SAP_HOST_INSTR_W-1:0] host_instruction,
	input  logic [`SAP_HOST_DATA_W-1:0]  host_data,
	input  logic                         sap_start,
	input  logic                         write_complete,
	input  logic                         data_input_ready,
	input  sap_slave_rsp_t               slave_rsp,
	output sap_slave_req_t               slave_req,
	output logic                         init_transaction,
	output logic                         sap_operation_done,
	output logic [`SAP_OUTPUT_W-1:0]     sap_output
);

	// controller to builder and store
	logic cmd_load;
	logic phase;
	logic capture;

	// decoded command back from the builder
	sap_opcode_e opcode;
	logic        supported;
	logic        operands_present;

	sap_controller u_controller (
		.clk                (clk),
		.rstn               (rstn),
		.sap_start          (sap_start),
		.write_complete     (write_complete),
		.data_input_ready   (data_input_ready),
		.supported          (supported),
		.operands_present   (operands_present),
		.cmd_load           (cmd_load),
		.phase              (phase),
		.capture            (capture),
		.init_transaction   (init_transaction),
		.sap_operation_done (sap_operation_done)
	);

	sap_request_builder u_request_builder (
		.clk              (clk),
		.rstn             (rstn),
		.host_instruction (host_instruction),
		.host_data        (host_data),
		.cmd_load         (cmd_load),
		.phase            (phase),
		.opcode           (opcode),
		.supported        (supported),
		.operands_present (operands_present),
		.slave_req        (slave_req)
	);

	sap_result_store u_result_store (
		.clk        (clk),
		.rstn       (rstn),
		.capture    (capture),
		.opcode     (opcode),
		.slave_rsp  (slave_rsp),
		.sap_output (sap_output)
	);

endmodule

// ==== hw/sap_result_store.sv ====
`timescale 1ns/1ps
`include "sap_settings.svh"

module sap_result_store
	import sap_pkg::*;
(
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     capture,
	input  sap_opcode_e              opcode,
	input  sap_slave_rsp_t           slave_rsp,
	output logic [`SAP_OUTPUT_W-1:0] sap_output
);

	logic [`SAP_OUTPUT_W-1:0] result_sel;

	// ####################
	// result select
	// ####################

	// pick the port of the slave that ran, upper bits stay zero
	always_comb begin
		result_sel = '0;
		case (opcode)
			OPC_ENCRYPT: begin
				result_sel[`SAP_AES_W-1:0] = slave_rsp.encrypt;
			end
			OPC_DECRYPT: begin
				result_sel[`SAP_AES_W-1:0] = slave_rsp.decrypt;
			end
			OPC_HASH: begin
				result_sel[`SAP_HASH_OUT_W-1:0] = slave_rsp.hash;
			end
			OPC_TRNG: begin
				result_sel[`SAP_TRNG_W-1:0] = slave_rsp.trng;
			end
			OPC_ODOMETER: begin
				result_sel[`SAP_ODO_OUT_W-1:0] = slave_rsp.odometer;
			end
			OPC_MULT: begin
				result_sel[`SAP_MULT_W-1:0] = slave_rsp.mult;
			end
			// rejected commands never capture, keep the last result
			default: begin
				result_sel = sap_output;
			end
		endcase
	end

	// ####################
	// output register
	// ####################

	// loads on the same edge the controller enters done
	always_ff @(posedge clk) begin
		if (!rstn) begin
			sap_output <= '0;
		end else if (capture) begin
			sap_output <= result_sel;
		end
	end

endmodule

// ==== hw/sap_controller.sv ====
`timescale 1ns/1ps

module sap_controller (
	input  logic clk,
	input  logic rstn,
	input  logic sap_start,
	input  logic write_complete,
	input  logic data_input_ready,
	input  logic supported,
	input  logic operands_present,
	output logic cmd_load,
	output logic phase,
	output logic capture,
	output logic init_transaction,
	output logic sap_operation_done
);

	// ####################
	// states
	// ####################

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		ST_CHECK = 3'd1,
		ST_WRITE = 3'd2,
		ST_READ  = 3'd3,
		ST_DONE  = 3'd4
	} state_e;

	state_e state_q;
	state_e state_d;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// ####################
	// next state
	// ####################

	always_comb begin
		state_d = state_q;
		case (state_q)
			// command gets latched on the same edge we leave idle
			ST_IDLE: begin
				if (sap_start) begin
					state_d = ST_CHECK;
				end
			end

			// decoded command is valid here, one cycle after the load
			ST_CHECK: begin
				if (supported) begin
					state_d = ST_WRITE;
				end else begin
					state_d = ST_DONE;
				end
			end

			// wait for the slave to take the operands
			ST_WRITE: begin
				if (write_complete) begin
					state_d = ST_READ;
				end
			end

			// result is captured on the edge that leaves read
			ST_READ: begin
				if (data_input_ready) begin
					state_d = ST_DONE;
				end
			end

			// host drops sap_start once it has seen done
			ST_DONE: begin
				if (!sap_start) begin
					state_d = ST_IDLE;
				end
			end

			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// ####################
	// outputs
	// ####################

	always_comb begin
		cmd_load           = 1'b0;
		phase              = 1'b0;
		capture            = 1'b0;
		init_transaction   = 1'b0;
		sap_operation_done = 1'b0;
		case (state_q)
			ST_IDLE: begin
				cmd_load = sap_start;
			end

			// zero operands hold the write off indefinitely
			ST_WRITE: begin
				init_transaction = operands_present;
			end

			// request drops in the strobe cycle, result goes to the store
			ST_READ: begin
				phase            = 1'b1;
				init_transaction = !data_input_ready;
				capture          = data_input_ready;
			end

			ST_DONE: begin
				sap_operation_done = 1'b1;
			end

			default: begin
				cmd_load = 1'b0;
			end
		endcase
	end

endmodule

// ==== hw/sap_request_builder.sv ====
`timescale 1ns/1ps
`include "sap_settings.svh"

module sap_request_builder
	import sap_pkg::*;
(
	input  logic                         clk,
	input  logic                         rstn,
	input  logic [`SAP_HOST_INSTR_W-1:0] host_instruction,
	input  logic [`SAP_HOST_DATA_W-1:0]  host_data,
	input  logic                         cmd_load,
	input  logic                         phase,
	output sap_opcode_e                  opcode,
	output logic                         supported,
	output logic                         operands_present,
	output sap_slave_req_t               slave_req
);

	logic [`SAP_CLASS_W-1:0]     class_q;
	logic [`SAP_OPCODE_W-1:0]    opcode_q;
	logic [`SAP_HOST_DATA_W-1:0] data_q;
	logic                        opcode_kept;

	// command fields, cleared so that op reads zero out of reset
	always_ff @(posedge clk) begin
		if (!rstn) begin
			class_q  <= '0;
			opcode_q <= '0;
		end else if (cmd_load) begin
			class_q  <= host_instruction[`SAP_HOST_INSTR_W-1:`SAP_CLASS_LSB];
			opcode_q <= host_instruction[`SAP_OPCODE_W-1:0];
		end
	end

	// host data is frozen here, later changes are ignored
	always_ff @(posedge clk) begin
		if (cmd_load) begin
			data_q <= host_data;
		end
	end

	assign opcode = sap_opcode_e'(opcode_q);

	always_comb begin
		case (opcode)
			OPC_ENCRYPT, OPC_DECRYPT, OPC_HASH,
			OPC_TRNG, OPC_ODOMETER, OPC_MULT: opcode_kept = 1'b1;
			default:                          opcode_kept = 1'b0;
		endcase
	end

	// secure class and unknown opcodes get rejected
	assign supported = opcode_kept && (class_q == CLASS_NON_SECURE);

	// ####################
	// operand slicing
	// ####################

	always_comb begin
		slave_req        = '0;
		operands_present = 1'b0;
		if (supported) begin
			case (opcode)
				OPC_ENCRYPT, OPC_DECRYPT: begin
					slave_req.text   = data_q[`SAP_AES_W-1:0];
					slave_req.key    = data_q[`SAP_KEY_LSB +: `SAP_AES_W];
					operands_present = |{slave_req.key, slave_req.text};
					if (opcode == OPC_ENCRYPT) begin
						slave_req.op = phase ? OP_ENCRYPT_RD : OP_ENCRYPT_WR;
					end else begin
						slave_req.op = phase ? OP_DECRYPT_RD : OP_DECRYPT_WR;
					end
				end
				OPC_HASH: begin
					slave_req.hash_block = data_q[`SAP_HASH_IN_W-1:0];
					operands_present     = |slave_req.hash_block;
					slave_req.op         = phase ? OP_HASH_RD : OP_HASH_WR;
				end
				// trng needs no operand at all
				OPC_TRNG: begin
					operands_present = 1'b1;
					slave_req.op     = phase ? OP_TRNG_RD : OP_TRNG_WR;
				end
				// a zero mode is still a valid selection
				OPC_ODOMETER: begin
					slave_req.odo_mode = data_q[`SAP_ODO_MODE_W-1:0];
					operands_present   = 1'b1;
					slave_req.op       = phase ? OP_ODO_RD : OP_ODO_WR;
				end
				OPC_MULT: begin
					slave_req.mult_a = data_q[`SAP_MULT_W-1:0];
					slave_req.mult_b = data_q[`SAP_MULT_B_LSB +: `SAP_MULT_W];
					operands_present = |{slave_req.mult_b, slave_req.mult_a};
					slave_req.op     = phase ? OP_MULT_RD : OP_MULT_WR;
				end
				default: begin
					slave_req = '0;
				end
			endcase
		end
	end

endmodule

// ==== hw/sap_pkg.sv ====
`include "sap_settings.svh"

package sap_pkg;

	// ####################
	// instruction fields
	// ####################

	// top two bits of the host instruction
	typedef enum logic [`SAP_CLASS_W-1:0] {
		CLASS_NON_SECURE = 2'b01,
		CLASS_SECURE     = 2'b10
	} sap_class_e;

	// low four bits, only the kept non-secure functions
	typedef enum logic [`SAP_OPCODE_W-1:0] {
		OPC_ENCRYPT  = 4'b0001,
		OPC_DECRYPT  = 4'b0010,
		OPC_HASH     = 4'b0011,
		OPC_TRNG     = 4'b0100,
		OPC_ODOMETER = 4'b0111,
		OPC_MULT     = 4'b1000
	} sap_opcode_e;

	// ####################
	// slave operations
	// ####################

	// write and read codes seen by the slaves on operation_type
	typedef enum logic [`SAP_OP_ENC_W-1:0] {
		OP_NONE       = 5'b00000,
		OP_ENCRYPT_WR = 5'b00001,
		OP_DECRYPT_WR = 5'b00010,
		OP_TRNG_WR    = 5'b00011,
		OP_HASH_WR    = 5'b00101,
		OP_ODO_WR     = 5'b00111,
		OP_MULT_WR    = 5'b01000,
		OP_ENCRYPT_RD = 5'b01001,
		OP_DECRYPT_RD = 5'b01010,
		OP_TRNG_RD    = 5'b01011,
		OP_HASH_RD    = 5'b01101,
		OP_ODO_RD     = 5'b01111,
		OP_MULT_RD    = 5'b10000
	} sap_op_enc_e;

	// operands and operation, master to slaves
	typedef struct packed {
		logic [`SAP_AES_W-1:0]      text;
		logic [`SAP_AES_W-1:0]      key;
		logic [`SAP_HASH_IN_W-1:0]  hash_block;
		logic [`SAP_ODO_MODE_W-1:0] odo_mode;
		logic [`SAP_MULT_W-1:0]     mult_a;
		logic [`SAP_MULT_W-1:0]     mult_b;
		sap_op_enc_e                op;
	} sap_slave_req_t;

	// result ports, slaves to master
	typedef struct packed {
		logic [`SAP_AES_W-1:0]      encrypt;
		logic [`SAP_AES_W-1:0]      decrypt;
		logic [`SAP_HASH_OUT_W-1:0] hash;
		logic [`SAP_TRNG_W-1:0]     trng;
		logic [`SAP_ODO_OUT_W-1:0]  odometer;
		logic [`SAP_MULT_W-1:0]     mult;
	} sap_slave_rsp_t;

endpackage

// ==== hw/sap_settings.svh ====
`ifndef SAP_SETTINGS_SVH
`define SAP_SETTINGS_SVH

// host side
`define SAP_HOST_INSTR_W 6
`define SAP_OPCODE_W     4
`define SAP_CLASS_W      2
`define SAP_CLASS_LSB    4
`define SAP_HOST_DATA_W  512
`define SAP_OUTPUT_W     512

// slave operand widths
`define SAP_AES_W        128
`define SAP_HASH_IN_W    512
`define SAP_ODO_MODE_W   5
`define SAP_MULT_W       128

// operand positions within the host data word
`define SAP_KEY_LSB      128
`define SAP_MULT_B_LSB   128

// slave result widths
`define SAP_HASH_OUT_W   256
`define SAP_TRNG_W       128
`define SAP_ODO_OUT_W    8

// operation_type encoding
`define SAP_OP_ENC_W     5

`endif
